// ==== src.f ====
logic/memSysPkg.sv
logic/memBusIf.sv
logic/cacheWay.sv
logic/waySelect.sv
logic/bankedMem.sv
logic/cacheCtrl.sv
logic/memSystem.sv
testbench/memSystemChecker.sv
testbench/memSystemTb.sv

// ==== Makefile ====
# Verilator build and run of the cache testbench
VERILATOR ?= verilator
TOP       ?= memSystemTb
FILELIST  ?= src.f
BUILDDIR  ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAILMSG   ?= Finished with errors
PASSMSG   ?= Finished with no errors

.PHONY: sim clean

# a run that stops before the pass message also counts as a failure
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG) || ! grep -q "$(PASSMSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILDDIR) $(LOG)

// ==== testbench/memSystemTb.sv ====
/* drives the cache top level through directed and random requests
   inputs change on the falling edge, memSystemChecker compares every result */
`timescale 1ns/100ps
`default_nettype none

module memSystemTb;
   import memSysPkg::*;

   localparam int directedRequests = 20;
   localparam int randomRequests   = 200;
   // a dirty miss with final write needs far fewer cycles than this
   localparam int cyclesPerRequest = 60;
   localparam int watchdogCycles   = (directedRequests + randomRequests) * cyclesPerRequest;

   logic                 clk = 1'b0;
   logic                 rstN;
   logic [addrWidth-1:0] Addr;
   logic [dataWidth-1:0] DataIn;
   logic                 Rd;
   logic                 Wr;
   logic [dataWidth-1:0] DataOut;
   logic                 Done;
   logic                 Stall;
   logic                 CacheHit;
   int                   chkErrors;
   int                   chkCount;
   int                   tbErrors;
   int                   shownErrors;
   int                   shownChecks;
   integer               seed;
   logic [31:0]          rnd;
   logic [dataWidth-1:0] rdWord;
   logic                 rdHit;
   int                   cycles;

   memSystem dut0 (
      .clk, .rstN, .Addr, .DataIn, .Rd, .Wr, .DataOut, .Done, .Stall, .CacheHit
   );

   memSystemChecker chk0 (
      .clk, .rstN, .Addr, .DataIn, .Rd, .Wr, .DataOut, .Done, .Stall, .CacheHit,
      .errorCount(chkErrors), .checkCount(chkCount)
   );

   always #5 clk = ~clk;

   function automatic logic [addrWidth-1:0] makeAddr(input logic [tagWidth-1:0] tag,
         input logic [indexWidth-1:0] index, input logic [wordSelWidth-1:0] word);
      return {tag, index, word, 1'b0};
   endfunction

   // request held from a falling edge until Done, then released
   task automatic request(input logic [addrWidth-1:0] addr,
         input logic [dataWidth-1:0] data, input logic isWrite);
      Addr   = addr;
      DataIn = data;
      Rd     = ~isWrite;
      Wr     = isWrite;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!Done);
      rdWord = DataOut;
      rdHit  = CacheHit;
      Rd     = 1'b0;
      Wr     = 1'b0;
   endtask

   task automatic expectValue(input string name, input logic [31:0] expected,
         input logic [31:0] actual);
      if (actual !== expected) begin
         tbErrors++;
         $display("[ERROR] %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
      end
   endtask

   task automatic reportTest(input string name);
      int errs;
      // checker compares at the edge that closes the Done cycle
      @(negedge clk);
      errs = tbErrors + chkErrors - shownErrors;
      $display("%-10s %3d requests checked, %0d errors", name, chkCount - shownChecks, errs);
      shownErrors = tbErrors + chkErrors;
      shownChecks = chkCount;
   endtask

   // ##############################
   initial begin
      seed        = 32'h5f35_da74;
      rstN        = 1'b0;
      Addr        = '0;
      DataIn      = '0;
      Rd          = 1'b0;
      Wr          = 1'b0;
      tbErrors    = 0;
      shownErrors = 0;
      shownChecks = 0;
      repeat (5) @(negedge clk);
      rstN = 1'b1;

      // quiet outputs with no request
      repeat (4) begin
         @(negedge clk);
         expectValue("{Done,CacheHit,Stall}", 32'd0, 32'({Done, CacheHit, Stall}));
      end
      reportTest("reset");

      // cold miss then a hit on another word of the line
      request(makeAddr(5'd3, 8'd1, 2'd0), '0, 1'b0);
      request(makeAddr(5'd3, 8'd1, 2'd2), '0, 1'b0);
      expectValue("hit latency", 32'd2, 32'(cycles));
      reportTest("coldRead");

      request(makeAddr(5'd4, 8'd2, 2'd1), 16'hbeef, 1'b1);
      request(makeAddr(5'd4, 8'd2, 2'd1), '0, 1'b0);
      reportTest("writeRead");

      // third tag evicts the dirty line of the first
      request(makeAddr(5'd1, 8'd9, 2'd0), 16'h1111, 1'b1);
      request(makeAddr(5'd2, 8'd9, 2'd0), 16'h2222, 1'b1);
      request(makeAddr(5'd3, 8'd9, 2'd0), 16'h3333, 1'b1);
      request(makeAddr(5'd1, 8'd9, 2'd0), '0, 1'b0);
      expectValue("CacheHit", 32'd0, 32'(rdHit));
      expectValue("DataOut", 32'h1111, 32'(rdWord));
      reportTest("eviction");

      // three tags rotate through two sets in turn
      for (int i = 0; i < 12; i++) begin
         request(makeAddr(5'((i / 2) % 3 + 1), 8'(5 + i % 2), 2'(i % 4)),
                 16'(i * 257), (i % 3) == 2);
      end
      reportTest("twoSets");

      // four tags over four sets keep evictions frequent
      for (int i = 0; i < randomRequests; i++) begin
         rnd = $random(seed);
         request(makeAddr({3'b000, rnd[1:0]}, {6'b000100, rnd[3:2]}, rnd[5:4]),
                 rnd[31:16], rnd[6]);
      end
      reportTest("random");

      $display("total %0d requests checked, %0d errors", chkCount, tbErrors + chkErrors);
      if (tbErrors + chkErrors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // ends a run whose requests never finish
   initial begin
      repeat (watchdogCycles) @(posedge clk);
      $display("timeout after %0d cycles, a request never got Done", watchdogCycles);
      $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/memSystemChecker.sv ====
/* reference model of the two-way cache over a zeroed memory, checked at every Done
   one request at a time, taken in idle or in the Done cycle of the previous one */
`timescale 1ns/100ps
`default_nettype none

module memSystemChecker (
   input  logic                            clk,
   input  logic                            rstN,
   input  logic [memSysPkg::addrWidth-1:0] Addr,
   input  logic [memSysPkg::dataWidth-1:0] DataIn,
   input  logic                            Rd,
   input  logic                            Wr,
   input  logic [memSysPkg::dataWidth-1:0] DataOut,
   input  logic                            Done,
   input  logic                            Stall,
   input  logic                            CacheHit,
   output int                              errorCount,
   output int                              checkCount
);
   import memSysPkg::*;

   // flat word memory always holds the newest value of every word
   logic [dataWidth-1:0] memModel [2 ** (addrWidth - 1)] = '{default: '0};
   logic [tagWidth-1:0]  tagModel [numSets][2];
   logic                 validModel [numSets][2];
   // one victim bit for the whole cache
   logic                 victimModel;
   logic                 busy;
   logic [addrWidth-1:0] pendAddr;
   logic [dataWidth-1:0] pendData;
   logic                 pendWrite;

   // hit way first, then an empty way with way 0 first, then the victim bit
   function automatic logic pickWay(input logic [tagWidth-1:0] tag,
         input logic [tagWidth-1:0] tagA, input logic [tagWidth-1:0] tagB,
         input logic validA, input logic validB, input logic victim);
      logic way;
      if (validA && tagA == tag) begin
         way = 1'b0;
      end else if (validB && tagB == tag) begin
         way = 1'b1;
      end else if (!validA) begin
         way = 1'b0;
      end else if (!validB) begin
         way = 1'b1;
      end else begin
         way = victim;
      end
      return way;
   endfunction

   // expected {hit, read word} of one request against one set of the model
   function automatic logic [dataWidth:0] expectResult(input logic [addrWidth-1:0] addr,
         input logic isWrite, input logic [tagWidth-1:0] tagA, input logic [tagWidth-1:0] tagB,
         input logic validA, input logic validB, input logic [dataWidth-1:0] memWord);
      logic [tagWidth-1:0]  tag;
      logic                 hit;
      logic [dataWidth-1:0] word;
      tag  = addr[addrWidth-1 -: tagWidth];
      hit  = (validA && tagA == tag) || (validB && tagB == tag);
      // write-back hides where the word lives, the value is the same
      word = isWrite ? '0 : memWord;
      return {hit, word};
   endfunction

   // ##############################
   always @(posedge clk) begin : checkDone
      logic [dataWidth:0]    expected;
      logic [indexWidth-1:0] idx;
      logic [tagWidth-1:0]   tag;
      logic                  way;
      logic                  stallExp;
      if (!rstN) begin
         busy        = 1'b0;
         victimModel = 1'b0;
         errorCount  = 0;
         checkCount  = 0;
         for (int s = 0; s < numSets; s++) begin
            validModel[s][0] = 1'b0;
            validModel[s][1] = 1'b0;
         end
      end else begin
         // stall is high while a request is open, low in idle and in the Done cycle
         stallExp = busy && !Done;
         if (Stall !== stallExp) begin
            errorCount = errorCount + 1;
            $display("[ERROR] %0d ns: Stall expected %b, got %b", $time, stallExp, Stall);
         end
         if (Done && busy) begin
            tag        = pendAddr[addrWidth-1 -: tagWidth];
            idx        = pendAddr[offsetWidth +: indexWidth];
            expected   = expectResult(pendAddr, pendWrite, tagModel[idx][0], tagModel[idx][1],
                                      validModel[idx][0], validModel[idx][1],
                                      memModel[pendAddr[addrWidth-1:1]]);
            checkCount = checkCount + 1;
            if (CacheHit !== expected[dataWidth]) begin
               errorCount = errorCount + 1;
               $display("[ERROR] %0d ns: CacheHit expected %b, got %b (Addr %h)",
                        $time, expected[dataWidth], CacheHit, pendAddr);
            end
            if (!pendWrite && DataOut !== expected[dataWidth-1:0]) begin
               errorCount = errorCount + 1;
               $display("[ERROR] %0d ns: DataOut expected %h, got %h (Addr %h)",
                        $time, expected[dataWidth-1:0], DataOut, pendAddr);
            end
            // update the model the way the cache does
            way = pickWay(tag, tagModel[idx][0], tagModel[idx][1],
                          validModel[idx][0], validModel[idx][1], victimModel);
            tagModel[idx][way]   = tag;
            validModel[idx][way] = 1'b1;
            if (pendWrite) begin
               memModel[pendAddr[addrWidth-1:1]] = pendData;
            end
            victimModel = ~victimModel;
         end else if (Done) begin
            errorCount = errorCount + 1;
            $display("%0d ns: Done was raised with no request outstanding", $time);
         end
         // a new request is taken in idle or in the Done cycle
         if ((!busy || Done) && (Rd ^ Wr)) begin
            pendAddr  = Addr;
            pendData  = DataIn;
            pendWrite = Wr;
            busy      = 1'b1;
         end else if (Done) begin
            busy = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/memSystem.sv ====
/* two-way write-back cache over a four-bank memory
   requester holds Addr, DataIn, Rd and Wr until Done */
`timescale 1ns/100ps
`default_nettype none

module memSystem (
   input  logic                            clk,
   input  logic                            rstN,
   input  logic [memSysPkg::addrWidth-1:0] Addr,
   input  logic [memSysPkg::dataWidth-1:0] DataIn,
   input  logic                            Rd,
   input  logic                            Wr,
   output logic [memSysPkg::dataWidth-1:0] DataOut,
   output logic                            Done,
   output logic                            Stall,
   output logic                            CacheHit
);
   import memSysPkg::*;

   memBusIf memBus ();

   // shared request bundle to both ways
   wayStatusT               status0;
   wayStatusT               status1;
   logic                    wayEnable;
   logic                    wayCompare;
   logic [tagWidth-1:0]     wayTag;
   logic [indexWidth-1:0]   wayIndex;
   logic [wordSelWidth-1:0] wayWord;
   logic [dataWidth-1:0]    wayWrData;
   // selector handshake
   logic                    cacheWrite;
   logic                    updateSel;
   logic                    requestDone;
   logic                    write0;
   logic                    write1;
   logic                    anyHit;
   logic                    victimDirty;
   logic [tagWidth-1:0]     victimTag;

   cacheCtrl ctrl0 (
      .clk, .rstN, .Addr, .DataIn, .Rd, .Wr,
      .anyHit, .victimDirty, .victimTag, .readData(DataOut),
      .Done, .Stall, .CacheHit,
      .enable(wayEnable), .compare(wayCompare), .tag(wayTag),
      .index(wayIndex), .word(wayWord), .wrData(wayWrData),
      .cacheWrite, .updateSel, .requestDone,
      .bus(memBus.ctrl)
   );

   cacheWay way0 (
      .clk, .rstN, .enable(wayEnable), .compare(wayCompare), .write(write0),
      .validIn(1'b1), .tag(wayTag), .index(wayIndex), .word(wayWord),
      .wrData(wayWrData), .status(status0)
   );

   cacheWay way1 (
      .clk, .rstN, .enable(wayEnable), .compare(wayCompare), .write(write1),
      .validIn(1'b1), .tag(wayTag), .index(wayIndex), .word(wayWord),
      .wrData(wayWrData), .status(status1)
   );

   waySelect sel0 (
      .clk, .rstN, .status0, .status1, .updateSel, .requestDone, .cacheWrite,
      .anyHit, .victimDirty, .victimTag, .readData(DataOut), .write0, .write1
   );

   bankedMem mem0 (
      .clk, .rstN, .bus(memBus.mem)
   );

endmodule

`default_nettype wire

// ==== logic/cacheCtrl.sv ====
/* miss and hit sequencing for the two-way cache
   the request is latched in idle and in the Done cycle, one request at a time */
`timescale 1ns/100ps
`default_nettype none

module cacheCtrl (
   input  logic                                clk,
   input  logic                                rstN,
   input  logic [memSysPkg::addrWidth-1:0]     Addr,
   input  logic [memSysPkg::dataWidth-1:0]     DataIn,
   input  logic                                Rd,
   input  logic                                Wr,
   input  logic                                anyHit,
   input  logic                                victimDirty,
   input  logic [memSysPkg::tagWidth-1:0]      victimTag,
   input  logic [memSysPkg::dataWidth-1:0]     readData,
   output logic                                Done,
   output logic                                Stall,
   output logic                                CacheHit,
   output logic                                enable,
   output logic                                compare,
   output logic [memSysPkg::tagWidth-1:0]      tag,
   output logic [memSysPkg::indexWidth-1:0]    index,
   output logic [memSysPkg::wordSelWidth-1:0]  word,
   output logic [memSysPkg::dataWidth-1:0]     wrData,
   output logic                                cacheWrite,
   output logic                                updateSel,
   output logic                                requestDone,
   memBusIf.ctrl                               bus
);
   import memSysPkg::*;

   ctrlStateT               state;
   ctrlStateT               nextState;
   ctrlStateT               reqState;
   logic [addrWidth-1:0]    reqAddr;
   logic [dataWidth-1:0]    reqData;
   logic                    reqWrite;
   logic                    takeReq;
   logic [tagWidth-1:0]     memTag;
   logic [wordSelWidth-1:0] memWord;

   // exactly one of Rd and Wr is a request
   assign reqState = (Rd ^ Wr) ? (Rd ? compRd : compWr) : idle;
   assign takeReq  = (state == idle) || Done;

   assign tag         = reqAddr[addrWidth-1 -: tagWidth];
   assign index       = reqAddr[offsetWidth +: indexWidth];
   assign bus.memAddr = {memTag, index, memWord, 1'b0};
   // eviction copies the victim word straight out
   assign bus.wrData  = readData;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         state <= idle;
      end else begin
         state <= nextState;
      end
   end

   always_ff @(posedge clk) begin
      if (takeReq) begin
         reqAddr  <= Addr;
         reqData  <= DataIn;
         reqWrite <= Wr;
      end
   end

   // ##############################
   // per-state outputs
   always_comb begin
      Done        = 1'b0;
      Stall       = 1'b1;
      CacheHit    = 1'b0;
      enable      = 1'b0;
      compare     = 1'b0;
      cacheWrite  = 1'b0;
      updateSel   = 1'b0;
      requestDone = 1'b0;
      word        = reqAddr[1 +: wordSelWidth];
      wrData      = reqData;
      bus.rd      = 1'b0;
      bus.wr      = 1'b0;
      memTag      = tag;
      memWord     = '0;
      case (state)
         idle: Stall = 1'b0;
         compRd, compWr: begin
            enable     = 1'b1;
            compare    = 1'b1;
            updateSel  = 1'b1;
            // ways drop the write on a miss
            cacheWrite = (state == compWr);
         end
         evict0, evict1, evict2, evict3: begin
            enable  = 1'b1;
            bus.wr  = 1'b1;
            memTag  = victimTag;
            memWord = wordSelWidth'(state - evict0);
            word    = memWord;
         end
         fill0, fill1: begin
            bus.rd  = 1'b1;
            memWord = wordSelWidth'(state - fill0);
         end
         // read beats 2 and 3 overlap the first cache writes
         fill2wb0, fill3wb1, wb2, wb3: begin
            bus.rd     = (state == fill2wb0) || (state == fill3wb1);
            memWord    = wordSelWidth'(state - fill0);
            enable     = 1'b1;
            cacheWrite = 1'b1;
            word       = wordSelWidth'(state - fill2wb0);
            wrData     = bus.rdData;
         end
         finalWrite: begin
            enable     = 1'b1;
            compare    = 1'b1;
            cacheWrite = 1'b1;
         end
         missDone, hitDone: begin
            Done        = 1'b1;
            Stall       = 1'b0;
            enable      = 1'b1;
            requestDone = 1'b1;
            CacheHit    = (state == hitDone);
         end
         default: Stall = 1'b1;
      endcase
   end

   // next state, memory beats advance by one when not stalled
   always_comb begin
      nextState = state;
      case (state)
         idle, missDone, hitDone: nextState = reqState;
         compRd, compWr: nextState = anyHit ? hitDone : (victimDirty ? evict0 : fill0);
         evict0, evict1, evict2, fill0, fill1, fill2wb0, fill3wb1: begin
            if (!bus.stall) begin
               nextState = ctrlStateT'(state + 1'b1);
            end
         end
         evict3: nextState = bus.stall ? evict3 : fill0;
         wb2: nextState = wb3;
         wb3: nextState = reqWrite ? finalWrite : missDone;
         finalWrite: nextState = missDone;
         default: nextState = idle;
      endcase
   end

   // memory stays quiet while a result is handed back
   doneQuiet: assert property (@(posedge clk) disable iff (!rstN)
      Done |-> !Stall && !(bus.rd || bus.wr));
   legalState: assert property (@(posedge clk) disable iff (!rstN)
      state inside {[idle:hitDone]});

endmodule

`default_nettype wire

// ==== logic/bankedMem.sv ====
/* four word-interleaved banks behind a stall handshake, contents start at zero
   a bank takes a new access bankBusyCycles after the last one it accepted */
`timescale 1ns/100ps
`default_nettype none

module bankedMem (
   input logic   clk,
   input logic   rstN,
   memBusIf.mem  bus
);
   import memSysPkg::*;

   logic [wordSelWidth-1:0] bankSel;
   logic [bankRowWidth-1:0] row;
   logic                    access;
   logic [wordsPerLine-1:0] bankBusy;
   logic [dataWidth-1:0]    bankOut [wordsPerLine];

   // word select bits pick the bank
   assign bankSel   = bus.memAddr[1 +: wordSelWidth];
   assign row       = bus.memAddr[addrWidth-1 -: bankRowWidth];
   assign access    = bus.rd | bus.wr;
   assign bus.stall = access & bankBusy[bankSel];

   for (genvar b = 0; b < wordsPerLine; b++) begin : genBank
      logic [dataWidth-1:0]      store [2 ** bankRowWidth] = '{default: '0};
      logic [busyCntWidth-1:0]   busyCnt;
      logic [dataWidth-1:0]      pipeData [memReadLatency];
      logic [memReadLatency-1:0] pipeValid;
      logic                      taken;

      // access accepted by this bank in this cycle
      assign taken       = access & ~bus.stall & (bankSel == wordSelWidth'(b));
      assign bankBusy[b] = (busyCnt != '0);

      always_ff @(posedge clk) begin
         if (taken && bus.wr) begin
            store[row] <= bus.wrData;
         end
      end

      // read pipeline moves on every cycle without stall
      always_ff @(posedge clk) begin
         if (!bus.stall) begin
            pipeData[0] <= store[row];
            for (int s = 1; s < memReadLatency; s++) begin
               pipeData[s] <= pipeData[s-1];
            end
         end
      end

      always_ff @(posedge clk) begin
         if (!rstN) begin
            busyCnt   <= '0;
            pipeValid <= '0;
         end else begin
            // access cycle counts as the first busy cycle
            if (taken) begin
               busyCnt <= busyCntWidth'(bankBusyCycles - 1);
            end else if (busyCnt != '0) begin
               busyCnt <= busyCnt - 1'b1;
            end
            if (!bus.stall) begin
               pipeValid <= {pipeValid[memReadLatency-2:0], taken & bus.rd};
            end
         end
      end

      assign bankOut[b] = pipeValid[memReadLatency-1] ? pipeData[memReadLatency-1] : '0;
   end

   // at most one bank has a word at the pipe end
   always_comb begin
      bus.rdData = '0;
      for (int i = 0; i < wordsPerLine; i++) begin
         bus.rdData = bus.rdData | bankOut[i];
      end
   end

endmodule

`default_nettype wire

// ==== logic/waySelect.sv ====
/* picks the way for a lookup or a fill out of two way statuses
   the choice is held while updateSel is low so a miss fills the compare-time way */
`timescale 1ns/100ps
`default_nettype none

module waySelect (
   input  logic                             clk,
   input  logic                             rstN,
   input  memSysPkg::wayStatusT             status0,
   input  memSysPkg::wayStatusT             status1,
   input  logic                             updateSel,
   input  logic                             requestDone,
   input  logic                             cacheWrite,
   output logic                             anyHit,
   output logic                             victimDirty,
   output logic [memSysPkg::tagWidth-1:0]   victimTag,
   output logic [memSysPkg::dataWidth-1:0]  readData,
   output logic                             write0,
   output logic                             write1
);

   logic hit0;
   logic hit1;
   logic victimBit;
   logic selNow;
   logic selHeld;
   logic wayChosen;

   assign hit0   = status0.tagHit & status0.valid;
   assign hit1   = status1.tagHit & status1.valid;
   assign anyHit = hit0 | hit1;

   // ##############################
   // way choice, 0 selects way 0
   // hit first, then an empty way (way 0 first), then the victim bit
   always_comb begin
      if (hit0) begin
         selNow = 1'b0;
      end else if (hit1) begin
         selNow = 1'b1;
      end else if (!status0.valid) begin
         selNow = 1'b0;
      end else if (!status1.valid) begin
         selNow = 1'b1;
      end else begin
         selNow = victimBit;
      end
   end

   assign wayChosen = updateSel ? selNow : selHeld;

   // outputs of the chosen way
   assign victimDirty = wayChosen ? status1.dirty : status0.dirty;
   assign victimTag   = wayChosen ? status1.tag : status0.tag;
   assign readData    = wayChosen ? status1.data : status0.data;
   assign write0      = cacheWrite & ~wayChosen;
   assign write1      = cacheWrite & wayChosen;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         selHeld   <= 1'b0;
         victimBit <= 1'b0;
      end else begin
         if (updateSel) begin
            selHeld <= selNow;
         end
         // flips once per finished request
         if (requestDone) begin
            victimBit <= ~victimBit;
         end
      end
   end

   oneWayWrite: assert property (@(posedge clk) disable iff (!rstN) !(write0 && write1));

endmodule

`default_nettype wire

// ==== logic/cacheWay.sv ====
/* one cache way with combinational lookup and write at the next edge
   only valid and dirty bits clear on reset, tag and data power up unknown */
`timescale 1ns/100ps
`default_nettype none

module cacheWay (
   input  logic                                clk,
   input  logic                                rstN,
   input  logic                                enable,
   input  logic                                compare,
   input  logic                                write,
   input  logic                                validIn,
   input  logic [memSysPkg::tagWidth-1:0]      tag,
   input  logic [memSysPkg::indexWidth-1:0]    index,
   input  logic [memSysPkg::wordSelWidth-1:0]  word,
   input  logic [memSysPkg::dataWidth-1:0]     wrData,
   output memSysPkg::wayStatusT                status
);
   import memSysPkg::*;

   logic [tagWidth-1:0]  tagMem  [numSets];
   logic [dataWidth-1:0] dataMem [numSets][wordsPerLine];
   logic [numSets-1:0]   validBits;
   logic [numSets-1:0]   dirtyBits;
   logic                 tagMatch;
   logic                 lineValid;
   logic                 fillWrite;
   logic                 wordWrite;

   assign tagMatch  = (tagMem[index] == tag);
   assign lineValid = validBits[index];

   // fill from memory ignores the tag compare
   assign fillWrite = enable & write & ~compare;
   // compare write only lands on a hit
   assign wordWrite = enable & write & compare & tagMatch & lineValid;

   // lookup, all zero while the way is idle
   always_comb begin
      status = '0;
      if (enable) begin
         status.tagHit = tagMatch;
         status.valid  = lineValid;
         status.dirty  = dirtyBits[index] & lineValid;
         status.tag    = tagMem[index];
         status.data   = dataMem[index][word];
      end
   end

   // storage arrays
   always_ff @(posedge clk) begin
      if (fillWrite) begin
         tagMem[index] <= tag;
      end
      if (fillWrite || wordWrite) begin
         dataMem[index][word] <= wrData;
      end
   end

   // line state
   always_ff @(posedge clk) begin
      if (!rstN) begin
         validBits <= '0;
         dirtyBits <= '0;
      end else if (fillWrite) begin
         validBits[index] <= validIn;
         dirtyBits[index] <= 1'b0;
      end else if (wordWrite) begin
         dirtyBits[index] <= 1'b1;
      end
   end

   // the write strobe comes from waySelect, the enable from the ctrl
   wrNeedsEnable: assert property (@(posedge clk) disable iff (!rstN) write |-> enable);

endmodule

`default_nettype wire

// ==== logic/memBusIf.sv ====
/* cache controller to banked memory link
   a request is held by the controller until stall drops */
`timescale 1ns/100ps
`default_nettype none

interface memBusIf;
   import memSysPkg::*;

   // request side
   logic [addrWidth-1:0] memAddr;
   logic [dataWidth-1:0] wrData;
   logic                 rd;
   logic                 wr;

   // response side
   // rdData lags an accepted read by memReadLatency cycles
   logic [dataWidth-1:0] rdData;
   logic                 stall;

   modport ctrl (
      output memAddr, wrData, rd, wr,
      input  rdData, stall
   );

   modport mem (
      input  memAddr, wrData, rd, wr,
      output rdData, stall
   );

endinterface

`default_nettype wire

// ==== logic/memSysPkg.sv ====
/* shared widths, timing and types for the cache and banked memory
   16-bit words at a 16-bit byte address, byte bit 0 is ignored */
`default_nettype none

package memSysPkg;

   // ##############################
   // address split tag | index | offset
   localparam int addrWidth   = 16;
   localparam int dataWidth   = 16;
   localparam int tagWidth    = 5;
   localparam int indexWidth  = 8;
   localparam int offsetWidth = 3;

   // line geometry
   localparam int wordsPerLine = 4;
   localparam int numSets      = 2 ** indexWidth;
   localparam int wordSelWidth = $clog2(wordsPerLine);

   // ##############################
   // memory timing
   localparam int memReadLatency = 2;
   localparam int bankBusyCycles = 4;
   // one row per line in every bank
   localparam int bankRowWidth   = addrWidth - offsetWidth;
   localparam int busyCntWidth   = $clog2(bankBusyCycles);

   // controller states
   // order matters, the ctrl steps evict and fill beats by +1
   typedef enum logic [4:0] {
      idle, compRd, compWr,
      evict0, evict1, evict2, evict3,
      fill0, fill1, fill2wb0, fill3wb1,
      wb2, wb3, finalWrite, missDone, hitDone
   } ctrlStateT;

   // lookup result of one way
   typedef struct packed {
      logic                 tagHit;
      logic                 valid;
      logic                 dirty;
      logic [tagWidth-1:0]  tag;
      logic [dataWidth-1:0] data;
   } wayStatusT;

endpackage

`default_nettype wire
